// ==== Bender.yml ====
package:
  name: tetris_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tetris_pkg.sv
      - rtl/drop_ctrl_if.sv
      - rtl/stack_port_if.sv
      - rtl/piece_drop.sv
      - rtl/stack_store.sv
      - rtl/game_ctrl.sv
      - rtl/tetris_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tetris_core_props.sv
      - dv/tb_tetris_core.sv

// ==== dv/tb_tetris_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tetris_cfg.svh"

module tb_tetris_core;
    typedef enum logic [1:0] {ACT_START, ACT_SPAWN, ACT_TICK, ACT_RAND} act_t;

    typedef struct {
        act_t               act;
        tetris_pkg::piece_t kind;
        int                 col;
        int                 lines;  // -1 leaves it to the model
        int                 over;
    } entry_t;

    logic                 clk;
    logic                 rst;
    logic                 start;
    logic                 spawn_req;
    tetris_pkg::piece_t   spawn_kind;
    tetris_pkg::col_idx_t spawn_col;
    logic                 tick;
    tetris_pkg::frame_t   frame;
    logic                 landed;
    tetris_pkg::cnt_t     lines_cleared;
    logic                 busy;
    logic                 game_over;

    entry_t      table_q[$];
    logic        table_ready = 1'b0;
    logic [31:0] lcg_state = 32'd32358;

    // Reference model
    tetris_pkg::frame_t m_stack;
    tetris_pkg::piece_t m_kind;
    int                 m_col;
    int                 m_y;
    int                 m_lines;
    bit                 m_falling;
    bit                 m_over;

    tetris_core UUT (
        .clk(clk), .rst(rst), .start(start),
        .spawn_req(spawn_req), .spawn_kind(spawn_kind), .spawn_col(spawn_col),
        .tick(tick), .frame(frame), .landed(landed),
        .lines_cleared(lines_cleared), .busy(busy), .game_over(game_over)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // One nibble per box row, top row in the low nibble, bit 0 leftmost
    function automatic logic [15:0] cell_pattern(tetris_pkg::piece_t k);
        case (k)
            tetris_pkg::I: return 16'h1111;
            tetris_pkg::O: return 16'h0033;
            tetris_pkg::L: return 16'h0311;
            tetris_pkg::J: return 16'h0322;
            tetris_pkg::S: return 16'h0036;
            tetris_pkg::Z: return 16'h0063;
            tetris_pkg::T: return 16'h0072;
            default:       return 16'h0000;
        endcase
    endfunction

    function automatic tetris_pkg::row_t placed_row(tetris_pkg::piece_t k, int r, int c);
        logic [15:0] p;
        p = cell_pattern(k);
        return tetris_pkg::row_t'(p[4*r +: 4]) << c;
    endfunction

    function automatic int piece_width(tetris_pkg::piece_t k);
        logic [15:0] p;
        int          w;
        p = cell_pattern(k);
        w = 0;
        for (int b = 0; b < 16; b++) begin
            if (p[b] && (b % 4) + 1 > w) w = (b % 4) + 1;
        end
        return w;
    endfunction

    function automatic bit fits(tetris_pkg::frame_t st, tetris_pkg::piece_t k, int c, int y);
        tetris_pkg::row_t pr;
        for (int r = 0; r < `TETRIS_BOX; r++) begin
            pr = placed_row(k, r, c);
            if (pr != '0 && (y + r >= `TETRIS_ROWS || (st[y + r] & pr) != '0)) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic tetris_pkg::frame_t overlay(tetris_pkg::frame_t st,
                                                   tetris_pkg::piece_t k, int c, int y);
        for (int r = 0; r < `TETRIS_BOX; r++) begin
            if (y + r < `TETRIS_ROWS) st[y + r] = st[y + r] | placed_row(k, r, c);
        end
        return st;
    endfunction

    function automatic tetris_pkg::frame_t model_frame();
        return m_falling ? overlay(m_stack, m_kind, m_col, m_y) : m_stack;
    endfunction

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    function automatic void add(act_t a, tetris_pkg::piece_t k, int c, int l, int o);
        table_q.push_back('{a, k, c, l, o});
    endfunction

    function automatic void add_drop(tetris_pkg::piece_t k, int c, int l, int o);
        add(ACT_SPAWN, k, c, -1, -1);
        add(ACT_TICK, k, c, l, o);
    endfunction

    task automatic model_settle();
        int r;
        m_stack   = overlay(m_stack, m_kind, m_col, m_y);
        m_falling = 1'b0;
        r = `TETRIS_ROWS - 1;
        while (r >= 0) begin
            if (m_stack[r] == '1) begin
                for (int k = r; k > 0; k--) m_stack[k] = m_stack[k - 1];
                m_stack[0] = '0;
                if (m_lines < (1 << `TETRIS_CNT_W) - 1) m_lines++;
            end else begin
                r--;  // Row stays, move up
            end
        end
    endtask

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_frame(string name, tetris_pkg::frame_t got, tetris_pkg::frame_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(string name, tetris_pkg::cnt_t got, tetris_pkg::cnt_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, bit got, bit exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Strobes sent in the first busy cycle must be dropped by the DUT
    task automatic wait_while_busy(output bit saw_landed);
        int n;
        saw_landed = 1'b0;
        n = 0;
        while (busy) begin
            if (n == 0) begin
                tick       = 1'b1;
                spawn_req  = 1'b1;
                spawn_kind = tetris_pkg::T;
            end
            step();
            tick      = 1'b0;
            spawn_req = 1'b0;
            if (landed) saw_landed = 1'b1;
            n++;
        end
    endtask

    task automatic do_start();
        start = 1'b1;
        step();
        start     = 1'b0;
        m_stack   = '0;
        m_falling = 1'b0;
        m_over    = 1'b0;
        m_lines   = 0;
        check_frame("frame", frame, model_frame());
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic do_spawn(tetris_pkg::piece_t k, int c);
        bit saw;
        spawn_kind = k;
        spawn_col  = tetris_pkg::col_idx_t'(c);
        spawn_req  = 1'b1;
        step();
        spawn_req = 1'b0;
        wait_while_busy(saw);
        if (!m_over && !m_falling) begin
            if (fits(m_stack, k, c, 0)) begin
                m_falling = 1'b1;
                m_kind    = k;
                m_col     = c;
                m_y       = 0;
            end else begin
                m_over = 1'b1;  // Blocked at row 0
            end
        end
        check_frame("frame", frame, model_frame());
        check_flag("game_over", game_over, m_over);
        if (m_falling) begin
            spawn_kind = tetris_pkg::O;  // Second spawn while falling
            spawn_col  = '0;
            spawn_req  = 1'b1;
            repeat (3) begin
                step();
                spawn_req = 1'b0;
                check_flag("busy", busy, 1'b0);
            end
            check_frame("frame", frame, model_frame());
        end
    endtask

    task automatic tick_until_landed();
        bit saw;
        bit exp;
        for (int n = 0; n < 25; n++) begin
            tick = 1'b1;
            step();
            tick = 1'b0;
            wait_while_busy(saw);
            if (fits(m_stack, m_kind, m_col, m_y + 1)) begin
                m_y++;
                exp = 1'b0;
            end else begin
                model_settle();
                exp = 1'b1;
            end
            check_flag("landed", saw, exp);
            check_frame("frame", frame, model_frame());
            if (exp) return;
        end
        $display("the piece did not land within 25 ticks");
        abort_run();
    endtask

    task automatic random_drop();
        tetris_pkg::piece_t k;
        int                 c;
        if (m_over) do_start();
        k = tetris_pkg::piece_t'(lcg_next() % 7);
        c = int'(lcg_next() % (`TETRIS_COLS - piece_width(k) + 1));
        do_spawn(k, c);
        if (m_falling) tick_until_landed();
    endtask

    task automatic apply_entry(entry_t e);
        case (e.act)
            ACT_START: do_start();
            ACT_SPAWN: do_spawn(e.kind, e.col);
            ACT_TICK:  tick_until_landed();
            default:   random_drop();
        endcase
        check_count("lines_cleared", lines_cleared, tetris_pkg::cnt_t'(m_lines));
        check_flag("game_over", game_over, m_over);
        if (e.lines >= 0) check_count("lines_cleared", lines_cleared, tetris_pkg::cnt_t'(e.lines));
        if (e.over >= 0) check_flag("game_over", game_over, e.over[0]);
    endtask

    function automatic void build_table();
        add(ACT_START, tetris_pkg::I, 0, 0, 0);
        add_drop(tetris_pkg::S, 0, 0, 0);  // Each kind on the floor
        add_drop(tetris_pkg::Z, 3, 0, 0);
        add_drop(tetris_pkg::T, 6, 0, 0);
        add(ACT_START, tetris_pkg::I, 0, 0, 0);
        add_drop(tetris_pkg::I, 0, 0, 0);
        add_drop(tetris_pkg::O, 1, 0, 0);
        add_drop(tetris_pkg::L, 3, 0, 0);
        add_drop(tetris_pkg::J, 5, 0, 0);
        add_drop(tetris_pkg::O, 7, 0, 0);
        add_drop(tetris_pkg::I, 9, 1, 0);  // Bottom row complete
        add_drop(tetris_pkg::O, 1, 1, 0);
        add_drop(tetris_pkg::O, 7, 1, 0);
        add_drop(tetris_pkg::O, 4, 3, 0);  // Two rows at once
        add_drop(tetris_pkg::S, 3, 3, 0);
        add_drop(tetris_pkg::Z, 3, 3, 0);
        add_drop(tetris_pkg::T, 5, 3, 0);
        add(ACT_START, tetris_pkg::I, 0, 0, 0);
        for (int n = 0; n < 5; n++) add_drop(tetris_pkg::I, 0, 0, 0);
        add(ACT_SPAWN, tetris_pkg::I, 0, 0, 1);
        add(ACT_SPAWN, tetris_pkg::O, 4, 0, 1);
        add(ACT_START, tetris_pkg::I, 0, 0, 0);
        for (int n = 0; n < 40; n++) add(ACT_RAND, tetris_pkg::I, 0, -1, -1);
    endfunction

    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(table_q.size()) * 25 * 60 * 4;
        #(limit_ns);
        $display("timeout: the run did not end within its time limit");
        abort_run();
    end

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        spawn_req  = 1'b0;
        spawn_kind = tetris_pkg::I;
        spawn_col  = '0;
        tick       = 1'b0;
        m_stack    = '0;
        m_kind     = tetris_pkg::I;
        m_col      = 0;
        m_y        = 0;
        m_lines    = 0;
        m_falling  = 1'b0;
        m_over     = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        check_frame("frame", frame, '0);
        check_count("lines_cleared", lines_cleared, '0);
        check_flag("landed", landed, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("game_over", game_over, 1'b0);
        foreach (table_q[i]) apply_entry(table_q[i]);
        $display("Everything OK");
        $finish;
    end
endmodule

`default_nettype wire

// ==== dv/tetris_core_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module tetris_core_props (
    input logic               clk,
    input logic               rst,
    input logic               landed,
    input logic               game_over,
    input logic               spawn,
    input logic               check,
    input logic               checked,
    input logic               hit,
    input logic               merge,
    input tetris_pkg::frame_t frame,
    input tetris_pkg::frame_t stack_frame
);
    landed_one_cycle: assert property (@(posedge clk) disable iff (rst) landed |=> !landed)
        else $error("landed stayed high for more than one cycle");

    // Four box rows, then the result strobe
    check_answered: assert property (@(posedge clk) disable iff (rst)
        (spawn || check) |-> ##[1:5] checked)
        else $error("no checked strobe within 5 cycles of a check");

    merge_after_hit: assert property (@(posedge clk) disable iff (rst)
        merge |-> $past(checked && hit))
        else $error("merge without a preceding hit");

    over_shows_stack: assert property (@(posedge clk) disable iff (rst)
        game_over |-> (frame == stack_frame))
        else $error("falling piece visible during game over");
endmodule

bind tetris_core tetris_core_props u_props (
    .clk(clk), .rst(rst), .landed(landed), .game_over(game_over),
    .spawn(ctl_bus.spawn), .check(ctl_bus.check),
    .checked(ctl_bus.checked), .hit(ctl_bus.hit),
    .merge(stk_bus.merge), .frame(frame), .stack_frame(stack_frame)
);

`default_nettype wire

// ==== rtl/drop_ctrl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface drop_ctrl_if;
    logic spawn;    // Load new piece at row 0 and check it there
    logic check;    // Test one row below the current position
    logic advance;  // Commit last check, move down or land
    logic checked;  // Check finished
    logic hit;      // Result, valid with checked

    modport ctrl (
        output spawn, check, advance,
        input  checked, hit
    );

    modport drop (
        input  spawn, check, advance,
        output checked, hit
    );
endinterface

`default_nettype wire

// ==== rtl/game_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       spawn_req,
    input  logic       tick,
    input  logic       settle_done,
    drop_ctrl_if.ctrl  ctl,
    output logic       landed,
    output logic       busy,
    output logic       game_over,
    output logic       clear_board
);
    tetris_pkg::ctrl_state_t state, state_n;
    logic falling;    // A piece is on the board
    logic spawn_chk;  // Current check came from a spawn
    logic spawn_go;
    logic tick_go;

    // External strobes are only honored in READY
    assign spawn_go = (state == tetris_pkg::READY) && spawn_req && !falling && !start;
    assign tick_go  = (state == tetris_pkg::READY) && tick && falling && !start;

    always_comb begin
        state_n = state;
        case (state)
            tetris_pkg::READY: if (spawn_go || tick_go) state_n = tetris_pkg::CHECK;
            tetris_pkg::CHECK: begin
                if (ctl.checked) begin
                    if (ctl.hit) begin
                        state_n = spawn_chk ? tetris_pkg::OVER : tetris_pkg::MERGE;
                    end else begin
                        state_n = spawn_chk ? tetris_pkg::READY : tetris_pkg::MOVE;
                    end
                end
            end
            tetris_pkg::MOVE:  state_n = tetris_pkg::READY;
            tetris_pkg::MERGE: state_n = tetris_pkg::CLEAR;
            tetris_pkg::CLEAR: if (settle_done) state_n = tetris_pkg::READY;
            default:           state_n = state;  // IDLE and OVER wait for start
        endcase
        if (start) state_n = tetris_pkg::READY;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= tetris_pkg::IDLE;
            falling   <= 1'b0;
            spawn_chk <= 1'b0;
        end else begin
            state <= state_n;
            if (spawn_go) begin
                falling   <= 1'b1;
                spawn_chk <= 1'b1;
            end else if (tick_go) begin
                spawn_chk <= 1'b0;
            end else if (state == tetris_pkg::CHECK && ctl.checked && ctl.hit) begin
                falling <= 1'b0;  // Landing or blocked spawn
            end
        end
    end

    assign ctl.spawn   = spawn_go;
    assign ctl.check   = tick_go;
    assign ctl.advance = (state == tetris_pkg::MOVE) || (state == tetris_pkg::MERGE);

    assign clear_board = start;
    assign landed      = (state == tetris_pkg::CLEAR) && settle_done;
    assign game_over   = (state == tetris_pkg::OVER);
    assign busy        = (state == tetris_pkg::CHECK) || (state == tetris_pkg::MOVE)
                      || (state == tetris_pkg::MERGE) || (state == tetris_pkg::CLEAR);
endmodule

`default_nettype wire

// ==== rtl/piece_drop.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tetris_cfg.svh"

module piece_drop (
    input  logic                 clk,
    input  logic                 rst,
    input  tetris_pkg::piece_t   spawn_kind,
    input  tetris_pkg::col_idx_t spawn_col,
    input  tetris_pkg::frame_t   stack_frame,
    drop_ctrl_if.drop            ctl,
    stack_port_if.drop           stk,
    output tetris_pkg::frame_t   frame
);
    tetris_pkg::piece_t                  kind;
    tetris_pkg::col_idx_t                col;
    tetris_pkg::row_idx_t                y;     // Board row of the box top
    tetris_pkg::row_idx_t                ty;    // Trial row of the running check
    tetris_pkg::row_idx_t                tr;
    tetris_pkg::shape_t                  shape;
    tetris_pkg::row_t [`TETRIS_BOX-1:0]  mask;
    logic [2:0]                          height;
    logic [1:0]                          cnt;
    logic                                checking;
    logic                                checked_q;
    logic                                hit_q;
    logic                                row_hit;
    logic                                spawn_chk;  // Running check is the spawn check
    logic                                live;       // Piece is shown

    assign shape  = tetris_pkg::piece_shape(kind);
    assign height = tetris_pkg::piece_height(kind);

    // Box rows placed at the piece column
    always_comb begin
        for (int r = 0; r < `TETRIS_BOX; r++) begin
            mask[r] = tetris_pkg::row_t'(shape[r]) << col;
        end
    end

    assign tr            = ty + tetris_pkg::row_idx_t'(cnt);
    assign stk.probe_row = tr;

    always_comb begin
        row_hit = 1'b0;
        if ({1'b0, cnt} < height) begin
            if (tr >= `TETRIS_ROWS) begin
                row_hit = 1'b1;  // Below the floor
            end else if ((mask[cnt] & stk.probe_data) != '0) begin
                row_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            checking  <= 1'b0;
            checked_q <= 1'b0;
            hit_q     <= 1'b0;
            cnt       <= '0;
            spawn_chk <= 1'b0;
            live      <= 1'b0;
        end else begin
            checked_q <= 1'b0;
            if (ctl.spawn || ctl.check) begin
                checking  <= 1'b1;
                cnt       <= '0;
                hit_q     <= 1'b0;
                spawn_chk <= ctl.spawn;
            end else if (checking) begin
                hit_q <= hit_q | row_hit;
                cnt   <= cnt + 1'b1;
                if (cnt == 2'd3) begin
                    checking  <= 1'b0;
                    checked_q <= 1'b1;
                end
            end
            if (ctl.spawn) begin
                live <= 1'b1;
            end else if (stk.merge || (checked_q && hit_q && spawn_chk)) begin
                live <= 1'b0;  // Landed, or blocked at spawn
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.spawn) begin
            kind <= spawn_kind;
            col  <= spawn_col;
            y    <= '0;
            ty   <= '0;
        end else if (ctl.check) begin
            ty <= y + 1'b1;
        end else if (ctl.advance && !hit_q) begin
            y <= y + 1'b1;
        end
    end

    assign ctl.checked    = checked_q;
    assign ctl.hit        = hit_q;
    assign stk.merge      = ctl.advance && hit_q;  // Advance after a hit lands the piece
    assign stk.merge_y    = y;
    assign stk.merge_mask = mask;

    always_comb begin
        frame = stack_frame;
        if (live) begin
            for (int r = 0; r < `TETRIS_BOX; r++) begin
                if (int'(y) + r < `TETRIS_ROWS) begin
                    frame[int'(y) + r] = frame[int'(y) + r] | mask[r];
                end
            end
        end
    end
endmodule

`default_nettype wire

// ==== rtl/stack_port_if.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tetris_cfg.svh"

interface stack_port_if;
    tetris_pkg::row_idx_t                    probe_row;
    tetris_pkg::row_t                        probe_data;   // Zero past the floor
    logic                                    merge;
    tetris_pkg::row_idx_t                    merge_y;      // Board row of box row 0
    tetris_pkg::row_t [`TETRIS_BOX-1:0]      merge_mask;
    logic                                    settle_done;  // Row scan finished

    modport drop (
        output probe_row, merge, merge_y, merge_mask,
        input  probe_data, settle_done
    );

    modport stack (
        input  probe_row, merge, merge_y, merge_mask,
        output probe_data, settle_done
    );
endinterface

`default_nettype wire

// ==== rtl/stack_store.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tetris_cfg.svh"

module stack_store (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear_board,
    stack_port_if.stack        stk,
    output tetris_pkg::frame_t stack_frame,
    output tetris_pkg::cnt_t   lines_cleared
);
    tetris_pkg::frame_t   cells;
    tetris_pkg::row_idx_t scan_row;
    logic                 scanning;
    logic                 row_full;
    logic                 done_q;

    assign stack_frame = cells;
    assign row_full    = (cells[scan_row] == '1);

    // Probe past the floor reads as empty
    assign stk.probe_data  = (stk.probe_row < `TETRIS_ROWS) ? cells[stk.probe_row] : '0;
    assign stk.settle_done = done_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cells         <= '0;
            scanning      <= 1'b0;
            scan_row      <= '0;
            lines_cleared <= '0;
            done_q        <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (clear_board) begin
                cells         <= '0;
                scanning      <= 1'b0;
                lines_cleared <= '0;
            end else if (stk.merge) begin
                for (int r = 0; r < `TETRIS_BOX; r++) begin
                    if (int'(stk.merge_y) + r < `TETRIS_ROWS) begin
                        cells[int'(stk.merge_y) + r] <=
                            cells[int'(stk.merge_y) + r] | stk.merge_mask[r];
                    end
                end
                scanning <= 1'b1;
                scan_row <= tetris_pkg::row_idx_t'(`TETRIS_ROWS - 1);  // Start at the bottom
            end else if (scanning) begin
                if (row_full) begin
                    // Drop everything above, then recheck the same row
                    for (int k = `TETRIS_ROWS - 1; k > 0; k--) begin
                        if (k <= int'(scan_row)) begin
                            cells[k] <= cells[k - 1];
                        end
                    end
                    cells[0] <= '0;
                    if (lines_cleared != '1) begin
                        lines_cleared <= lines_cleared + 1'b1;
                    end
                end else if (scan_row == '0) begin
                    scanning <= 1'b0;
                    done_q   <= 1'b1;
                end else begin
                    scan_row <= scan_row - 1'b1;
                end
            end
        end
    end
endmodule

`default_nettype wire

// ==== rtl/tetris_cfg.svh ====
`ifndef TETRIS_CFG_SVH
`define TETRIS_CFG_SVH

// Board size in cells
`define TETRIS_ROWS 20
`define TETRIS_COLS 10

// Side of the square box that holds any piece
`define TETRIS_BOX 4

// Width of the cleared-row counter
`define TETRIS_CNT_W 8

`endif

// ==== rtl/tetris_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tetris_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 spawn_req,
    input  tetris_pkg::piece_t   spawn_kind,
    input  tetris_pkg::col_idx_t spawn_col,
    input  logic                 tick,
    output tetris_pkg::frame_t   frame,
    output logic                 landed,
    output tetris_pkg::cnt_t     lines_cleared,
    output logic                 busy,
    output logic                 game_over
);
    tetris_pkg::frame_t stack_frame;
    logic               clear_board;

    drop_ctrl_if  ctl_bus ();
    stack_port_if stk_bus ();

    game_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .start(start), .spawn_req(spawn_req), .tick(tick),
        .settle_done(stk_bus.settle_done),
        .ctl(ctl_bus.ctrl),
        .landed(landed), .busy(busy), .game_over(game_over),
        .clear_board(clear_board)
    );

    piece_drop u_drop (
        .clk(clk), .rst(rst),
        .spawn_kind(spawn_kind), .spawn_col(spawn_col),
        .stack_frame(stack_frame),
        .ctl(ctl_bus.drop), .stk(stk_bus.drop),
        .frame(frame)
    );

    stack_store u_stack (
        .clk(clk), .rst(rst), .clear_board(clear_board),
        .stk(stk_bus.stack),
        .stack_frame(stack_frame), .lines_cleared(lines_cleared)
    );
endmodule

`default_nettype wire

// ==== rtl/tetris_pkg.sv ====
`default_nettype none
`include "tetris_cfg.svh"

package tetris_pkg;

    typedef logic [`TETRIS_COLS-1:0]          row_t;     // Bit 0 is the leftmost column
    typedef row_t [`TETRIS_ROWS-1:0]          frame_t;   // Row 0 is the top
    typedef logic [$clog2(`TETRIS_ROWS)-1:0]  row_idx_t;
    typedef logic [$clog2(`TETRIS_COLS)-1:0]  col_idx_t;
    typedef logic [`TETRIS_BOX-1:0]           box_row_t;
    typedef box_row_t [`TETRIS_BOX-1:0]       shape_t;
    typedef logic [`TETRIS_CNT_W-1:0]         cnt_t;

    typedef enum logic [2:0] {I, O, L, J, S, Z, T} piece_t;

    typedef enum logic [2:0] {IDLE, READY, CHECK, MOVE, MERGE, CLEAR, OVER} ctrl_state_t;

    // Box rows listed bottom row first, each left-aligned
    function automatic shape_t piece_shape(piece_t kind);
        case (kind)
            I:       piece_shape = {4'b0001, 4'b0001, 4'b0001, 4'b0001};
            O:       piece_shape = {4'b0000, 4'b0000, 4'b0011, 4'b0011};
            L:       piece_shape = {4'b0000, 4'b0011, 4'b0001, 4'b0001};
            J:       piece_shape = {4'b0000, 4'b0011, 4'b0010, 4'b0010};
            S:       piece_shape = {4'b0000, 4'b0000, 4'b0011, 4'b0110};
            Z:       piece_shape = {4'b0000, 4'b0000, 4'b0110, 4'b0011};
            T:       piece_shape = {4'b0000, 4'b0000, 4'b0111, 4'b0010};
            default: piece_shape = '0;
        endcase
    endfunction

    function automatic logic [2:0] piece_height(piece_t kind);
        case (kind)
            I:       piece_height = 3'd4;
            L, J:    piece_height = 3'd3;
            default: piece_height = 3'd2;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== tetris_core.f ====
+incdir+rtl
rtl/tetris_pkg.sv
rtl/drop_ctrl_if.sv
rtl/stack_port_if.sv
rtl/piece_drop.sv
rtl/stack_store.sv
rtl/game_ctrl.sv
rtl/tetris_core.sv
dv/tetris_core_props.sv
dv/tb_tetris_core.sv
